/* bcd_field_adjust.sv */
`timescale 1ns/100ps

module bcd_field_adjust
	import rtc_field_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  field_t sel_field,
	input  logic   editing,
	input  logic   arriba,
	input  logic   abajo,
	input  bcd_t   cur_value,
	output bcd_t   new_value,
	output logic   adj_en
);

	//////////////////////////////////////////////////
	// BCD step with wrap at the field limits
	//////////////////////////////////////////////////

	function automatic bcd_t bcd_inc(input bcd_t v, input field_t f);
		bcd_t r;
		if (v >= field_max(f))
			r = field_min(f);
		else if (v[3:0] >= 4'd9)
			r = {v[7:4] + 4'd1, 4'd0};
		else
			r = v + 8'd1;
		return r;
	endfunction

	function automatic bcd_t bcd_dec(input bcd_t v, input field_t f);
		bcd_t r;
		if (v <= field_min(f))
			r = field_max(f);
		else if (v[3:0] == 4'd0)
			r = {v[7:4] - 4'd1, 4'd9};
		else
			r = v - 8'd1;
		return r;
	endfunction

	// Both buttons at once cancel out
	assign adj_en    = editing && (arriba != abajo);
	assign new_value = arriba ? bcd_inc(cur_value, sel_field)
	                          : bcd_dec(cur_value, sel_field);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Written value is valid BCD and inside the field range
	a_new_value_bcd: assert property (@(posedge clk) disable iff (reset)
		adj_en |-> (new_value[7:4] <= 4'd9) && (new_value[3:0] <= 4'd9)
			&& (new_value >= field_min(sel_field))
			&& (new_value <= field_max(sel_field)));

endmodule

/* commit_sequencer.sv */
`timescale 1ns/100ps

module commit_sequencer
	import rtc_field_pkg::*;
	import rtc_bus_pkg::*;
#(
	parameter logic [BUS_ADDR_W-1:0] REG_BASE = DEFAULT_REG_BASE
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  commit_start,
	output field_t                rd_field,
	input  bcd_t                  rd_value,
	output logic                  wr_valid,
	output logic [BUS_ADDR_W-1:0] wr_addr,
	output logic [BUS_DATA_W-1:0] wr_data,
	input  logic                  wr_ready,
	output logic                  commit_busy
);

	logic [3:0] beat_cnt;
	logic [3:0] rd_cnt;
	logic       beat_done;
	logic       last_beat;
	logic       load;

	assign beat_done = wr_valid && wr_ready;
	assign last_beat = (beat_cnt == 4'(NUM_FIELDS - 1));

	// Look one field ahead on a transfer so beats run back to back
	assign rd_cnt   = (beat_done && !last_beat) ? beat_cnt + 4'd1 : beat_cnt;
	assign rd_field = field_t'(rd_cnt);

	assign load = (!commit_busy && commit_start) || (beat_done && !last_beat);

	//////////////////////////////////////////////////
	// Beat counter and handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			beat_cnt    <= 4'd0;
			wr_valid    <= 1'b0;
			commit_busy <= 1'b0;
		end else if (!commit_busy) begin
			if (commit_start) begin
				beat_cnt    <= 4'd0;
				wr_valid    <= 1'b1;
				commit_busy <= 1'b1;
			end
		end else if (beat_done) begin
			if (last_beat) begin
				beat_cnt    <= 4'd0;
				wr_valid    <= 1'b0;
				commit_busy <= 1'b0;
			end else begin
				beat_cnt <= rd_cnt;
			end
		end
	end

	// Address and data hold while the bus stalls
	always_ff @(posedge clk) begin
		if (load) begin
			wr_addr <= REG_BASE + BUS_ADDR_W'(rd_cnt);
			wr_data <= BUS_DATA_W'(rd_value);
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data));

	a_cnt_range: assert property (@(posedge clk) disable iff (reset)
		beat_cnt <= 4'(NUM_FIELDS - 1));

endmodule

/* field_pointer_fsm.sv */
`timescale 1ns/100ps

module field_pointer_fsm
	import rtc_field_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   interr,
	input  logic   derecha,
	input  logic   commit_busy,
	output field_t field,
	output logic   editing,
	output logic   commit_start
);

	// Idle plus one state per field, field code is state minus one
	typedef enum logic [3:0] {
		st_idle,
		st_clk_sec,
		st_clk_min,
		st_clk_hour,
		st_day,
		st_month,
		st_year,
		st_tmr_sec,
		st_tmr_min,
		st_tmr_hour
	} state_t;

	state_t state;
	state_t next_state;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				// Wait until the previous commit has read the store
				if (interr && !commit_busy && !commit_start)
					next_state = st_clk_sec;
			end
			st_clk_sec, st_clk_min, st_clk_hour, st_day, st_month,
			st_year, st_tmr_sec, st_tmr_min: begin
				if (derecha)
					next_state = state_t'(state + 4'd1);
			end
			st_tmr_hour: begin
				if (derecha)
					next_state = st_clk_sec;
			end
			default: next_state = st_idle;
		endcase
		// Leaving edit mode always returns to idle
		if (!interr)
			next_state = st_idle;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state        <= st_idle;
			commit_start <= 1'b0;
		end else begin
			state        <= next_state;
			commit_start <= (state != st_idle) && !interr && !commit_busy;
		end
	end

	assign editing = (state != st_idle);
	assign field   = (state == st_idle) ? fld_clk_sec : field_t'(state - 4'd1);

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	a_field_legal: assert property (@(posedge clk) disable iff (reset)
		field inside {[fld_clk_sec:fld_tmr_hour]});

	// Store must not change under a running commit
	a_edit_not_busy: assert property (@(posedge clk) disable iff (reset)
		editing |-> !commit_busy);

endmodule

/* field_store.sv */
`timescale 1ns/100ps

module field_store
	import rtc_field_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  field_t sel_field,
	input  logic   adj_en,
	input  bcd_t   new_value,
	output bcd_t   cur_value,
	input  field_t rd_field,
	output bcd_t   rd_value
);

	//////////////////////////////////////////////////
	// Field registers
	//////////////////////////////////////////////////

	// One byte per field in enumeration order
	bcd_t field_regs [NUM_FIELDS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_FIELDS; i++)
				field_regs[i] <= field_reset(field_t'(i));
		end else if (adj_en) begin
			// Edit port writes the field under the cursor
			field_regs[sel_field] <= new_value;
		end
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Editor sees the selected field for the next step
	assign cur_value = field_regs[sel_field];

	// Commit sequencer walks the fields one beat at a time
	assign rd_value = field_regs[rd_field];

endmodule

/* rtc_bus_pkg.sv */
package rtc_bus_pkg;

	//////////////////////////////////////////////////
	// RTC register bus
	//////////////////////////////////////////////////

	// Address and data widths of one write beat
	localparam int BUS_ADDR_W = 8;
	localparam int BUS_DATA_W = 8;

	// First register of the nine field registers
	// Field i lands at base plus i
	localparam logic [BUS_ADDR_W-1:0] DEFAULT_REG_BASE = 8'h21;

	// Address of one field register
	typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

	// One data beat
	typedef logic [BUS_DATA_W-1:0] bus_data_t;

endpackage

/* rtc_field_pkg.sv */
package rtc_field_pkg;

	//////////////////////////////////////////////////
	// Field enumeration in cursor order
	//////////////////////////////////////////////////

	localparam int NUM_FIELDS = 9;

	typedef enum logic [3:0] {
		fld_clk_sec  = 4'd0,
		fld_clk_min  = 4'd1,
		fld_clk_hour = 4'd2,
		fld_day      = 4'd3,
		fld_month    = 4'd4,
		fld_year     = 4'd5,
		fld_tmr_sec  = 4'd6,
		fld_tmr_min  = 4'd7,
		fld_tmr_hour = 4'd8
	} field_t;

	// Two BCD digits, tens in the upper nibble
	typedef logic [7:0] bcd_t;

	//////////////////////////////////////////////////
	// Per-field limits
	//////////////////////////////////////////////////

	function automatic bcd_t field_min(input field_t f);
		case (f)
			fld_day, fld_month: return 8'h01;
			default:            return 8'h00;
		endcase
	endfunction

	function automatic bcd_t field_max(input field_t f);
		case (f)
			fld_clk_hour, fld_tmr_hour: return 8'h23;
			fld_day:                    return 8'h31;
			fld_month:                  return 8'h12;
			fld_year:                   return 8'h99;
			default:                    return 8'h59;
		endcase
	endfunction

	// Power-up value of each field
	function automatic bcd_t field_reset(input field_t f);
		return field_min(f);
	endfunction

endpackage

/* rtc_setup_top.f */
rtc_field_pkg.sv
rtc_bus_pkg.sv
field_pointer_fsm.sv
bcd_field_adjust.sv
field_store.sv
commit_sequencer.sv
rtc_setup_top.sv
tb_clock_gen.sv
tb_rtc_setup.sv

/* rtc_setup_top.sv */
`timescale 1ns/100ps

module rtc_setup_top
	import rtc_field_pkg::*;
	import rtc_bus_pkg::*;
#(
	parameter logic [BUS_ADDR_W-1:0] REG_BASE = DEFAULT_REG_BASE
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  interr,
	input  logic                  derecha,
	input  logic                  arriba,
	input  logic                  abajo,
	output logic                  wr_valid,
	output logic [BUS_ADDR_W-1:0] wr_addr,
	output logic [BUS_DATA_W-1:0] wr_data,
	input  logic                  wr_ready,
	output field_t                field,
	output logic                  editing,
	output logic                  commit_busy
);

	logic   commit_start;
	logic   adj_en;
	bcd_t   cur_value;
	bcd_t   new_value;
	field_t rd_field;
	bcd_t   rd_value;

	//////////////////////////////////////////////////
	// Edit path
	//////////////////////////////////////////////////

	field_pointer_fsm u_fsm (
		.clk          (clk),
		.reset        (reset),
		.interr       (interr),
		.derecha      (derecha),
		.commit_busy  (commit_busy),
		.field        (field),
		.editing      (editing),
		.commit_start (commit_start)
	);

	bcd_field_adjust u_adjust (
		.clk       (clk),
		.reset     (reset),
		.sel_field (field),
		.editing   (editing),
		.arriba    (arriba),
		.abajo     (abajo),
		.cur_value (cur_value),
		.new_value (new_value),
		.adj_en    (adj_en)
	);

	field_store u_store (
		.clk       (clk),
		.reset     (reset),
		.sel_field (field),
		.adj_en    (adj_en),
		.new_value (new_value),
		.cur_value (cur_value),
		.rd_field  (rd_field),
		.rd_value  (rd_value)
	);

	//////////////////////////////////////////////////
	// Commit path
	//////////////////////////////////////////////////

	commit_sequencer #(
		.REG_BASE (REG_BASE)
	) u_commit (
		.clk          (clk),
		.reset        (reset),
		.commit_start (commit_start),
		.rd_field     (rd_field),
		.rd_value     (rd_value),
		.wr_valid     (wr_valid),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wr_ready     (wr_ready),
		.commit_busy  (commit_busy)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Release lands a few ns after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		reset = 1'b0;
	end

endmodule

/* tb_rtc_setup.sv */
`timescale 1ns/100ps

module tb_rtc_setup
	import rtc_field_pkg::*;
();

	localparam logic [7:0] BASE = 8'h21;
	localparam int KEY_RIGHT = 0;
	localparam int KEY_UP    = 1;
	localparam int KEY_DOWN  = 2;
	localparam int KEY_BOTH  = 3;

	logic clk, reset;
	logic interr, derecha, arriba, abajo, wr_ready;
	logic wr_valid, editing, commit_busy;
	logic [7:0] wr_addr, wr_data;
	field_t field;

	logic [7:0] exp_vals [9];
	logic [3:0] exp_cursor, exp_beat;
	logic exp_editing;
	logic exp_start;
	logic exp_busy;
	logic [7:0] held_addr, held_data;
	logic stall_q;
	int seed = 6067;
	int errors = 0;
	int beat_total = 0;
	int commit_count = 0;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(2)) u_clk (.clk(clk), .reset(reset));

	rtc_setup_top #(.REG_BASE(BASE)) uut (
		.clk(clk), .reset(reset), .interr(interr), .derecha(derecha),
		.arriba(arriba), .abajo(abajo), .wr_valid(wr_valid), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_ready(wr_ready), .field(field),
		.editing(editing), .commit_busy(commit_busy)
	);

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		errors++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
		stop_run();
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error: %s", msg);
		stop_run();
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Field limits as plain decimal numbers
	function automatic int field_lo(input int idx);
		return (idx == 3 || idx == 4) ? 1 : 0;
	endfunction

	function automatic int field_hi(input int idx);
		case (idx)
			2, 8:    return 23;
			3:       return 31;
			4:       return 12;
			5:       return 99;
			default: return 59;
		endcase
	endfunction

	function automatic logic [7:0] to_bcd(input int d);
		logic [7:0] r;
		r[7:4] = 4'(d / 10);
		r[3:0] = 4'(d % 10);
		return r;
	endfunction

	function automatic logic [7:0] step_value(input int idx, input logic [7:0] v, input logic up);
		int d;
		d = v[7:4] * 10 + v[3:0];
		if (up)
			d = (d >= field_hi(idx)) ? field_lo(idx) : d + 1;
		else
			d = (d <= field_lo(idx)) ? field_hi(idx) : d - 1;
		return to_bcd(d);
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			exp_cursor  <= 4'd0;
			exp_beat    <= 4'd0;
			exp_editing <= 1'b0;
			exp_start   <= 1'b0;
			exp_busy    <= 1'b0;
			stall_q     <= 1'b0;
			for (int i = 0; i < 9; i++)
				exp_vals[i] <= to_bcd(field_lo(i));
		end else begin
			// Edit mode waits until no commit is pending
			exp_editing <= interr && (exp_editing || (!exp_busy && !exp_start));
			exp_start   <= exp_editing && !interr;
			if (exp_start && !exp_busy)
				exp_busy <= 1'b1;
			else if (exp_busy && wr_ready && exp_beat == 4'd8)
				exp_busy <= 1'b0;
			// Cursor restarts at clock seconds whenever editing is not running
			if (!interr || !exp_editing)
				exp_cursor <= 4'd0;
			else if (derecha)
				exp_cursor <= (exp_cursor == 4'd8) ? 4'd0 : exp_cursor + 4'd1;
			if (exp_editing && (arriba != abajo))
				exp_vals[exp_cursor] <= step_value(exp_cursor, exp_vals[exp_cursor], arriba);
			if (exp_busy && wr_ready)
				exp_beat <= (exp_beat == 4'd8) ? 4'd0 : exp_beat + 4'd1;
			if (wr_valid && wr_ready)
				beat_total <= beat_total + 1;
			stall_q <= wr_valid && !wr_ready;
		end
		held_addr <= wr_addr;
		held_data <= wr_data;
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	chk_reset_state: assert property (@(posedge clk) $fell(reset) |->
		!wr_valid && !commit_busy && !editing)
		else report_error("outputs not idle after reset");
	chk_field: assert property (@(posedge clk) disable iff (reset) field == exp_cursor)
		else report_mismatch("field", $sampled(field), $sampled(exp_cursor));
	chk_editing: assert property (@(posedge clk) disable iff (reset) editing == exp_editing)
		else report_mismatch("editing", $sampled(editing), $sampled(exp_editing));
	chk_busy: assert property (@(posedge clk) disable iff (reset) commit_busy == exp_busy)
		else report_mismatch("commit_busy", $sampled(commit_busy), $sampled(exp_busy));
	chk_valid: assert property (@(posedge clk) disable iff (reset) wr_valid == exp_busy)
		else report_mismatch("wr_valid", $sampled(wr_valid), $sampled(exp_busy));
	chk_addr: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> wr_addr == 8'(BASE + exp_beat))
		else report_mismatch("wr_addr", $sampled(wr_addr), $sampled(8'(BASE + exp_beat)));
	chk_data: assert property (@(posedge clk) disable iff (reset)
		wr_valid |-> wr_data == exp_vals[exp_beat])
		else report_mismatch("wr_data", $sampled(wr_data), $sampled(exp_vals[exp_beat]));
	chk_hold_valid: assert property (@(posedge clk) disable iff (reset) stall_q |-> wr_valid)
		else report_error("wr_valid dropped before its beat transferred");
	chk_hold_addr: assert property (@(posedge clk) disable iff (reset)
		stall_q |-> wr_addr == held_addr)
		else report_mismatch("wr_addr", $sampled(wr_addr), $sampled(held_addr));
	chk_hold_data: assert property (@(posedge clk) disable iff (reset)
		stall_q |-> wr_data == held_data)
		else report_mismatch("wr_data", $sampled(wr_data), $sampled(held_data));
	chk_busy_edit: assert property (@(posedge clk) disable iff (reset)
		commit_busy |-> !editing)
		else report_error("editing went high while a commit was busy");

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Random back-pressure from the RTC bus
	always @(posedge clk) begin
		#5;
		wr_ready = ($random(seed) % 2) != 0;
	end

	task automatic press(input int key, input int times);
		for (int i = 0; i < times; i++) begin
			derecha = (key == KEY_RIGHT);
			arriba  = (key == KEY_UP) || (key == KEY_BOTH);
			abajo   = (key == KEY_DOWN) || (key == KEY_BOTH);
			@(posedge clk);
			#5;
			derecha = 1'b0;
			arriba  = 1'b0;
			abajo   = 1'b0;
			@(posedge clk);
			#5;
		end
	endtask

	task automatic wait_editing(input int limit);
		int n;
		n = 0;
		while (editing !== 1'b1 && n < limit) begin
			@(posedge clk);
			#5;
			n++;
		end
		if (editing !== 1'b1)
			report_error("edit mode did not start");
	endtask

	task automatic wait_busy(input logic want, input int limit);
		int n;
		n = 0;
		while (commit_busy !== want && n < limit) begin
			@(posedge clk);
			#5;
			n++;
		end
		if (commit_busy !== want)
			report_error(want ? "commit did not start after edit mode ended"
				: "commit did not finish within 200 cycles");
	endtask

	task automatic enter_edit();
		interr = 1'b1;
		wait_editing(300);
	endtask

	task automatic leave_and_commit();
		interr = 1'b0;
		commit_count++;
		wait_busy(1'b1, 10);
		wait_busy(1'b0, 200);
	endtask

	initial begin
		int n;
		interr   = 1'b0;
		derecha  = 1'b0;
		arriba   = 1'b0;
		abajo    = 1'b0;
		wr_ready = 1'b0;
		n = 0;
		while (reset !== 1'b0 && n < 10) begin
			@(posedge clk);
			n++;
		end
		if (reset !== 1'b0)
			report_error("reset never released");
		@(posedge clk);
		#5;

		// Reset values straight to the bus
		enter_edit();
		leave_and_commit();

		// Cursor walk with wrap and leave at day
		enter_edit();
		press(KEY_RIGHT, 12);
		leave_and_commit();

		// Limits of every field
		enter_edit();
		press(KEY_DOWN, 1);
		press(KEY_UP, 1);
		press(KEY_DOWN, 1);
		press(KEY_RIGHT, 1);
		press(KEY_UP, 12);
		press(KEY_RIGHT, 1);
		press(KEY_DOWN, 1);
		press(KEY_UP, 1);
		press(KEY_DOWN, 2);
		press(KEY_RIGHT, 1);
		press(KEY_DOWN, 1);
		press(KEY_UP, 1);
		press(KEY_DOWN, 3);
		press(KEY_RIGHT, 1);
		press(KEY_DOWN, 1);
		press(KEY_UP, 1);
		press(KEY_DOWN, 1);
		press(KEY_RIGHT, 1);
		press(KEY_DOWN, 1);
		press(KEY_UP, 1);
		press(KEY_DOWN, 11);
		press(KEY_RIGHT, 1);
		press(KEY_UP, 61);
		press(KEY_RIGHT, 1);
		press(KEY_BOTH, 2);
		press(KEY_UP, 10);
		press(KEY_RIGHT, 1);
		press(KEY_UP, 25);
		leave_and_commit();

		// Buttons outside edit mode are ignored
		press(KEY_UP, 3);
		press(KEY_DOWN, 2);
		press(KEY_BOTH, 1);
		press(KEY_RIGHT, 2);
		enter_edit();
		leave_and_commit();

		// Edit mode requested while the commit is still running
		enter_edit();
		press(KEY_UP, 5);
		interr = 1'b0;
		commit_count++;
		wait_busy(1'b1, 10);
		interr = 1'b1;
		wait_busy(1'b0, 200);
		wait_editing(10);
		press(KEY_RIGHT, 4);
		press(KEY_UP, 3);
		leave_and_commit();

		repeat (4) @(posedge clk);
		if (beat_total != 9 * commit_count)
			report_mismatch("beat count", 8'(beat_total), 8'(9 * commit_count));
		if (errors != 0) begin
			stop_run();
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule
